// ==== fpu_add_sub_top.f ====
fpu_pkg.sv
fpu_classify.sv
fpu_align.sv
fpu_normalize.sv
fpu_add_sub_pipe.sv
fpu_add_sub_top.sv
tb_fpu_add_sub.sv

// ==== Makefile ====
# Verilator build and run for the fp add/sub unit

VERILATOR ?= verilator
TOP       ?= tb_fpu_add_sub
FILELIST  ?= fpu_add_sub_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_fpu_add_sub.sv ====
`timescale 1ns/1ns
//////////////////////////////
// testbench for the fp add/sub unit
// queue of expected results, checked by
// concurrent assertions on every taken result
//////////////////////////////
module tb_fpu_add_sub;

  localparam int max_cycles_lp = 400;
  localparam fpu_pkg::fpu_flags_t f_none = '0;
  localparam fpu_pkg::fpu_flags_t f_inv = fpu_pkg::fpu_flags_t'(1 << fpu_pkg::flag_invalid_idx);
  localparam fpu_pkg::fpu_flags_t f_ovf = fpu_pkg::fpu_flags_t'(1 << fpu_pkg::flag_overflow_idx);
  localparam fpu_pkg::fpu_flags_t f_unf = fpu_pkg::fpu_flags_t'(1 << fpu_pkg::flag_underflow_idx);
  localparam fpu_pkg::fpu_flags_t f_uni = fpu_pkg::fpu_flags_t'(1 << fpu_pkg::flag_unimpl_idx);

  logic clk_i = 1'b0;
  logic reset_i, v_i, sub_i, ready_o, v_o, yumi_i;
  logic take_en, random_take, check_latency, have_head;
  logic [31:0] a_i, b_i, z_o, exp_z_in;
  fpu_pkg::fpu_flags_t flags_o, exp_f_in;
  logic [35:0] exp_q[$];
  logic [35:0] head_r;
  int acc_q[$];
  int head_cyc;
  int cyc = 0;
  int n_sent = 0;
  int n_taken = 0;
  int n_checks = 0;
  int n_errors = 0;
  int test_checks = 0;
  int test_errors = 0;
  integer seed = 32'h9db6;
  string test_name = "reset";

  always #50 clk_i = ~clk_i;

  // consumer takes whenever it is willing and a result is there
  assign yumi_i = (v_o === 1'b1) & take_en;

  fpu_add_sub_top #(
    .exp_width_p(fpu_pkg::exp_width_default),
    .man_width_p(fpu_pkg::man_width_default)
  ) i_dut (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(v_i), .a_i(a_i), .b_i(b_i), .sub_i(sub_i), .ready_o(ready_o),
    .v_o(v_o), .z_o(z_o), .flags_o(flags_o), .yumi_i(yumi_i)
  );

  // single precision pattern of a small signed integer
  function automatic logic [31:0] encode_int(input int n);
    int mag;
    int msb;
    logic [31:0] bits;
    mag = (n < 0) ? -n : n;
    if (mag == 0) return 32'h0;
    msb = 0;
    for (int i = 0; i < 31; i++) begin
      if (mag[i]) msb = i;
    end
    bits[31] = n < 0;
    bits[30:23] = 8'(127 + msb);
    bits[22:0] = 23'(mag << (23 - msb));
    return bits;
  endfunction

  task automatic mismatch_error(input string what, input logic [35:0] exp_v,
                                input logic [35:0] act_v);
    n_errors++;
    $display("ERR %s: %s expected %h, actual %h", test_name, what, exp_v, act_v);
  endtask

  task automatic plain_error(input string msg);
    n_errors++;
    $display("test %s: %s", test_name, msg);
  endtask

  task automatic send_op(input logic [31:0] a, input logic [31:0] b, input logic sub,
                         input logic [31:0] z, input fpu_pkg::fpu_flags_t f);
    v_i <= 1'b1;
    a_i <= a;
    b_i <= b;
    sub_i <= sub;
    exp_z_in <= z;
    exp_f_in <= f;
    @(posedge clk_i);
    while (!ready_o) @(posedge clk_i);
  endtask

  task automatic wait_drain();
    v_i <= 1'b0;
    @(posedge clk_i);
    while (exp_q.size() != 0) @(posedge clk_i);
    // let the checks of the last result settle
    @(posedge clk_i);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_checks = n_checks;
    test_errors = n_errors;
  endtask

  task automatic end_test();
    $display("test %s done: %0d results checked, %0d failures", test_name,
             n_checks - test_checks, n_errors - test_errors);
  endtask

  // pop before push, head is visible from the next edge on
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (reset_i) begin
      have_head <= 1'b0;
    end else begin
      if (v_o && yumi_i) begin
        n_taken++;
        if (exp_q.size() != 0) begin
          void'(exp_q.pop_front());
          void'(acc_q.pop_front());
          n_checks++;
        end
      end
      if (v_i && ready_o) begin
        exp_q.push_back({exp_z_in, exp_f_in});
        acc_q.push_back(cyc);
        n_sent++;
      end
      have_head <= exp_q.size() != 0;
      if (exp_q.size() != 0) begin
        head_r <= exp_q[0];
        head_cyc <= acc_q[0];
      end
    end
  end

  always @(posedge clk_i) begin
    if (random_take) take_en <= ($random(seed) % 2) == 0;
    else take_en <= 1'b1;
  end

  always @(posedge clk_i) begin
    if (cyc >= max_cycles_lp) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles_lp);
      $display("Errors found");
      $finish;
    end
  end

  a_idle: assert property (@(posedge clk_i) $fell(reset_i) |-> (!v_o && ready_o))
    else plain_error("pipe not idle right after reset");
  a_queued: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o && yumi_i) |-> have_head)
    else plain_error("result taken while nothing was expected");
  a_result: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o && yumi_i && have_head) |-> ({z_o, flags_o} == head_r))
    else mismatch_error("z_o/flags_o", $sampled(head_r), $sampled({z_o, flags_o}));
  a_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o && yumi_i && have_head && check_latency) |-> (cyc == head_cyc + 3))
    else mismatch_error("taken at cycle", 36'($sampled(head_cyc) + 3), 36'($sampled(cyc)));
  a_stall_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o && !yumi_i) |-> !ready_o)
    else plain_error("ready_o high while the output was stalled");
  a_stall_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o && !yumi_i) |=> $stable(z_o))
    else plain_error("z_o changed while the output was stalled");

  initial begin
    int ra;
    int rb;
    reset_i = 1'b1;
    v_i = 1'b0;
    a_i = '0;
    b_i = '0;
    sub_i = 1'b0;
    exp_z_in = '0;
    exp_f_in = '0;
    take_en = 1'b1;
    random_take = 1'b0;
    check_latency = 1'b1;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);

    begin_test("latency");
    send_op(encode_int(1), encode_int(2), 1'b0, encode_int(3), f_none);
    send_op(encode_int(5), encode_int(8), 1'b1, encode_int(-3), f_none);
    send_op(encode_int(-40), encode_int(7), 1'b0, encode_int(-33), f_none);
    wait_drain();
    send_op(encode_int(12), encode_int(-4), 1'b1, encode_int(16), f_none);
    wait_drain();
    end_test();

    begin_test("exact");
    for (int i = 0; i < 20; i++) begin
      ra = $random(seed) % 1001;
      rb = $random(seed) % 1001;
      send_op(encode_int(ra), encode_int(rb), i[0],
              encode_int(i[0] ? ra - rb : ra + rb), f_none);
    end
    // x - x is an exact +0
    send_op(encode_int(ra), encode_int(ra), 1'b1, 32'h0, f_none);
    wait_drain();
    end_test();

    begin_test("specials");
    send_op(32'h7f800001, encode_int(1), 1'b0, 32'h7f800001, f_inv);
    send_op(encode_int(1), 32'h7fc00000, 1'b0, 32'h7fc00000, f_none);
    send_op(32'h7f800000, 32'h7f800000, 1'b1, 32'h7fc00000, f_inv);
    send_op(encode_int(3), 32'hff800000, 1'b0, 32'hff800000, f_none);
    send_op(32'h00000010, encode_int(2), 1'b0, 32'h7fc00000, f_uni);
    wait_drain();
    end_test();

    begin_test("limits");
    send_op(32'h7f7fffff, 32'h7f7fffff, 1'b0, 32'h7f800000, f_ovf);
    send_op(32'h00800000, 32'h00800001, 1'b1, 32'h80000000, f_unf);
    // a tie stays on the even fraction, above the tie rounds up
    send_op(32'h3f800000, 32'h33800000, 1'b0, 32'h3f800000, f_none);
    send_op(32'h3f800000, 32'h34400000, 1'b0, 32'h3f800002, f_none);
    wait_drain();
    end_test();

    begin_test("backpressure");
    check_latency <= 1'b0;
    random_take <= 1'b1;
    for (int i = 0; i < 16; i++) begin
      ra = $random(seed) % 1001;
      rb = $random(seed) % 1001;
      send_op(encode_int(ra), encode_int(rb), 1'b0, encode_int(ra + rb), f_none);
    end
    wait_drain();
    random_take <= 1'b0;
    end_test();

    if (exp_q.size() != 0 || n_sent != n_taken) begin
      plain_error("accepted operations and taken results do not pair up");
    end
    $display("%0d results checked, %0d failures", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== fpu_add_sub_top.sv ====
`timescale 1ns/1ns
//////////////////////////////
// fp add/sub top level
// sets the widths and wraps the pipeline
//////////////////////////////
module fpu_add_sub_top #(
  parameter int exp_width_p = fpu_pkg::exp_width_default,
  parameter int man_width_p = fpu_pkg::man_width_default
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             v_i,
  input  logic [exp_width_p+man_width_p:0] a_i,
  input  logic [exp_width_p+man_width_p:0] b_i,
  input  logic                             sub_i,
  output logic                             ready_o,
  output logic                             v_o,
  output logic [exp_width_p+man_width_p:0] z_o,
  output fpu_pkg::fpu_flags_t              flags_o,
  input  logic                             yumi_i
);

  fpu_add_sub_pipe #(
    .exp_width_p(exp_width_p),
    .man_width_p(man_width_p)
  ) i_pipe (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(v_i), .a_i(a_i), .b_i(b_i), .sub_i(sub_i), .ready_o(ready_o),
    .v_o(v_o), .z_o(z_o), .flags_o(flags_o), .yumi_i(yumi_i)
  );

endmodule

// ==== fpu_add_sub_pipe.sv ====
`timescale 1ns/1ns
//////////////////////////////
// fp add/sub pipeline
// align, add, normalize in three stages, then
// round and special-case selection on the output
//////////////////////////////
module fpu_add_sub_pipe #(
  parameter int exp_width_p = fpu_pkg::exp_width_default,
  parameter int man_width_p = fpu_pkg::man_width_default
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             v_i,
  input  logic [exp_width_p+man_width_p:0] a_i,
  input  logic [exp_width_p+man_width_p:0] b_i,
  input  logic                             sub_i,
  output logic                             ready_o,
  output logic                             v_o,
  output logic [exp_width_p+man_width_p:0] z_o,
  output fpu_pkg::fpu_flags_t              flags_o,
  input  logic                             yumi_i
);

  // aligned mantissa, and the sum with its carry bit
  localparam int mw_lp = man_width_p + fpu_pkg::grs_width + 1;
  localparam int sw_lp = mw_lp + 1;
  localparam logic [exp_width_p-1:0] exp_ones_lp = '1;
  // operand class bits carried down the pipe
  localparam int c_snan_lp = 4;
  localparam int c_nan_lp = 3;
  localparam int c_a_inf_lp = 2;
  localparam int c_b_inf_lp = 1;
  localparam int c_den_lp = 0;

  logic v_1_r, v_2_r, v_3_r;
  logic sign_a, sign_b, a_nan, b_nan, a_snan, b_snan, a_inf, b_inf, a_den, b_den;
  logic [exp_width_p-1:0] exp_a, exp_b, exp_0, exp_1_r, exp_2_r, exp_n, exp_3_r;
  logic [man_width_p-1:0] man_a, man_b, man_n, man_3_r;
  logic sign_0, do_sub_0, sign_1_r, do_sub_1_r, sign_2_r, do_sub_2_r, sign_3_r, do_sub_3_r;
  logic [mw_lp-1:0] big_man_0, small_man_0, big_1_r, small_1_r, larger, smaller;
  logic [4:0] cls_0, cls_1_r, cls_2_r, cls_3_r;
  logic big_less;
  logic [sw_lp-1:0] sum_1, sum_2_r;
  logic round_up_n, all_zero_n, borrow_n, round_up_3_r, all_zero_3_r, borrow_3_r;
  logic round_carry;
  logic [exp_width_p+man_width_p-1:0] rounded;
  logic [exp_width_p-1:0] rounded_exp;
  logic [exp_width_p+man_width_p:0] qnan_pat, snan_pat, inf_pat;

  // whole pipe holds while the result waits
  assign ready_o = ~(v_3_r & ~yumi_i);
  assign v_o = v_3_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_1_r <= 1'b0;
      v_2_r <= 1'b0;
      v_3_r <= 1'b0;
    end else if (ready_o) begin
      v_1_r <= v_i;
      v_2_r <= v_1_r;
      v_3_r <= v_2_r;
    end
  end

  fpu_classify #(.exp_width_p(exp_width_p), .man_width_p(man_width_p)) i_class_a (
    .a_i(a_i), .sign_o(sign_a), .exp_o(exp_a), .man_o(man_a), .zero_o(),
    .nan_o(a_nan), .sig_nan_o(a_snan), .infty_o(a_inf), .denormal_o(a_den)
  );

  fpu_classify #(.exp_width_p(exp_width_p), .man_width_p(man_width_p)) i_class_b (
    .a_i(b_i), .sign_o(sign_b), .exp_o(exp_b), .man_o(man_b), .zero_o(),
    .nan_o(b_nan), .sig_nan_o(b_snan), .infty_o(b_inf), .denormal_o(b_den)
  );

  fpu_align #(.exp_width_p(exp_width_p), .man_width_p(man_width_p)) i_align (
    .a_i(a_i), .b_i(b_i), .sub_i(sub_i), .sign_a_i(sign_a), .sign_b_i(sign_b),
    .exp_a_i(exp_a), .exp_b_i(exp_b), .man_a_i(man_a), .man_b_i(man_b),
    .sign_o(sign_0), .do_sub_o(do_sub_0), .exp_o(exp_0),
    .big_man_o(big_man_0), .small_man_o(small_man_0)
  );

  assign cls_0 = {a_snan | b_snan, a_nan | b_nan, a_inf, b_inf, a_den | b_den};

  always_ff @(posedge clk_i) begin
    if (ready_o & v_i) begin
      sign_1_r   <= sign_0;
      do_sub_1_r <= do_sub_0;
      exp_1_r    <= exp_0;
      big_1_r    <= big_man_0;
      small_1_r  <= small_man_0;
      cls_1_r    <= cls_0;
    end
  end

  // equal exponents can still leave the far operand larger
  assign big_less = big_1_r < small_1_r;
  assign larger   = big_less ? small_1_r : big_1_r;
  assign smaller  = big_less ? big_1_r : small_1_r;
  assign sum_1    = do_sub_1_r ? ({1'b0, larger} - {1'b0, smaller})
                               : ({1'b0, larger} + {1'b0, smaller});

  always_ff @(posedge clk_i) begin
    if (ready_o & v_1_r) begin
      sign_2_r   <= sign_1_r;
      do_sub_2_r <= do_sub_1_r;
      exp_2_r    <= exp_1_r;
      sum_2_r    <= sum_1;
      cls_2_r    <= cls_1_r;
    end
  end

  fpu_normalize #(.exp_width_p(exp_width_p), .man_width_p(man_width_p)) i_norm (
    .sum_i(sum_2_r), .exp_i(exp_2_r), .exp_o(exp_n), .man_o(man_n),
    .round_up_o(round_up_n), .all_zero_o(all_zero_n), .exp_borrow_o(borrow_n)
  );

  always_ff @(posedge clk_i) begin
    if (ready_o & v_2_r) begin
      sign_3_r     <= sign_2_r;
      do_sub_3_r   <= do_sub_2_r;
      exp_3_r      <= exp_n;
      man_3_r      <= man_n;
      round_up_3_r <= round_up_n;
      all_zero_3_r <= all_zero_n;
      borrow_3_r   <= borrow_n;
      cls_3_r      <= cls_2_r;
    end
  end

  // a fraction carry ripples into the exponent
  assign {round_carry, rounded} = {1'b0, exp_3_r, man_3_r}
                                + (exp_width_p+man_width_p+1)'(round_up_3_r);
  assign rounded_exp = rounded[man_width_p +: exp_width_p];

  assign qnan_pat = {sign_3_r, exp_ones_lp, 1'b1, {(man_width_p-1){1'b0}}};
  assign snan_pat = {sign_3_r, exp_ones_lp, {(man_width_p-1){1'b0}}, 1'b1};
  assign inf_pat  = {sign_3_r, exp_ones_lp, {man_width_p{1'b0}}};

  always_comb begin
    flags_o = '0;
    z_o = {sign_3_r, rounded};
    if (cls_3_r[c_snan_lp]) begin
      z_o = snan_pat;
      flags_o[fpu_pkg::flag_invalid_idx] = 1'b1;
    end else if (cls_3_r[c_nan_lp]) begin
      z_o = qnan_pat;
    end else if (cls_3_r[c_a_inf_lp] & cls_3_r[c_b_inf_lp] & do_sub_3_r) begin
      z_o = qnan_pat;
      flags_o[fpu_pkg::flag_invalid_idx] = 1'b1;
    end else if (cls_3_r[c_a_inf_lp] | cls_3_r[c_b_inf_lp]) begin
      z_o = inf_pat;
    end else if (cls_3_r[c_den_lp]) begin
      z_o = qnan_pat;
      flags_o[fpu_pkg::flag_unimpl_idx] = 1'b1;
    end else if (all_zero_3_r) begin
      // exact cancellation gives +0, zero plus zero keeps its sign
      z_o = {sign_3_r & ~do_sub_3_r, {(exp_width_p+man_width_p){1'b0}}};
    end else if (borrow_3_r | ((rounded_exp == '0) & ~round_carry)) begin
      z_o = {sign_3_r, {(exp_width_p+man_width_p){1'b0}}};
      flags_o[fpu_pkg::flag_underflow_idx] = 1'b1;
    end else if (round_carry | (rounded_exp == exp_ones_lp)) begin
      z_o = inf_pat;
      flags_o[fpu_pkg::flag_overflow_idx] = 1'b1;
    end
  end

  // held result must not move under back-pressure
  a_hold_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o & ~yumi_i) |=> ($stable(z_o) && $stable(flags_o)))
    else $error("pipe: output changed while stalled");

  a_yumi_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o)
    else $error("pipe: yumi without a valid result");

  a_one_flag: assert property (@(posedge clk_i) disable iff (reset_i)
    v_o |-> $onehot0(flags_o))
    else $error("pipe: more than one exception flag");

endmodule

// ==== fpu_normalize.sv ====
`timescale 1ns/1ns
//////////////////////////////
// fp normalizer
// leading zero count and shift of the raw sum,
// exponent adjust and round-to-nearest-even bit
//////////////////////////////
module fpu_normalize #(
  parameter int exp_width_p = fpu_pkg::exp_width_default,
  parameter int man_width_p = fpu_pkg::man_width_default
) (
  input  logic [man_width_p+fpu_pkg::grs_width+1:0] sum_i,
  input  logic [exp_width_p-1:0]                    exp_i,
  output logic [exp_width_p-1:0]                    exp_o,
  output logic [man_width_p-1:0]                    man_o,
  output logic                                      round_up_o,
  output logic                                      all_zero_o,
  output logic                                      exp_borrow_o
);

  localparam int sum_width_lp = man_width_p + fpu_pkg::grs_width + 2;
  localparam int cnt_width_lp = $clog2(sum_width_lp + 1);

  logic [cnt_width_lp-1:0] zcount;
  logic [sum_width_lp-1:0] shifted;
  logic                    guard;
  logic                    round_bit;
  logic                    sticky;

  // scan up from the lsb so the topmost one wins
  always_comb begin
    zcount = cnt_width_lp'(sum_width_lp);
    for (int i = 0; i < sum_width_lp; i++) begin
      if (sum_i[i]) begin
        zcount = cnt_width_lp'(sum_width_lp - 1 - i);
      end
    end
  end

  assign all_zero_o = ~|sum_i;
  assign shifted    = sum_i << zcount;
  assign {exp_borrow_o, exp_o} = {1'b0, exp_i} - (exp_width_p+1)'(zcount);

  // leading one sits in the msb and is dropped
  assign man_o     = shifted[fpu_pkg::grs_width+1 +: man_width_p];
  assign guard     = shifted[fpu_pkg::grs_width];
  assign round_bit = shifted[fpu_pkg::grs_width-1];
  assign sticky    = |shifted[fpu_pkg::grs_width-2:0];

  // ties go to the even fraction
  assign round_up_o = guard & (round_bit | sticky | man_o[0]);

  always_comb begin
    assert (all_zero_o || shifted[sum_width_lp-1])
      else $error("normalize: leading one not in the msb");
  end

endmodule

// ==== fpu_align.sv ====
`timescale 1ns/1ns
//////////////////////////////
// fp operand alignment
// orders operands by exponent, shifts the smaller
// one right with sticky, picks sign and operation
//////////////////////////////
module fpu_align #(
  parameter int exp_width_p = fpu_pkg::exp_width_default,
  parameter int man_width_p = fpu_pkg::man_width_default
) (
  input  logic [exp_width_p+man_width_p:0]          a_i,
  input  logic [exp_width_p+man_width_p:0]          b_i,
  input  logic                                      sub_i,
  input  logic                                      sign_a_i,
  input  logic                                      sign_b_i,
  input  logic [exp_width_p-1:0]                    exp_a_i,
  input  logic [exp_width_p-1:0]                    exp_b_i,
  input  logic [man_width_p-1:0]                    man_a_i,
  input  logic [man_width_p-1:0]                    man_b_i,
  output logic                                      sign_o,
  output logic                                      do_sub_o,
  output logic [exp_width_p-1:0]                    exp_o,
  output logic [man_width_p+fpu_pkg::grs_width:0]   big_man_o,
  output logic [man_width_p+fpu_pkg::grs_width:0]   small_man_o
);

  // hidden bit, fraction, guard and round
  localparam int pad_width_lp = man_width_p + fpu_pkg::grs_width;

  logic                    exp_a_less;
  logic                    mag_a_less;
  logic [exp_width_p-1:0]  exp_diff;
  logic [man_width_p:0]    man_a_norm;
  logic [man_width_p:0]    man_b_norm;
  logic [man_width_p:0]    big_norm;
  logic [man_width_p:0]    small_norm;
  logic [pad_width_lp-1:0] small_pad;
  logic [pad_width_lp-1:0] lost_mask;
  logic                    sticky;

  assign exp_a_less = exp_a_i < exp_b_i;
  assign exp_diff   = exp_a_less ? exp_b_i - exp_a_i : exp_a_i - exp_b_i;
  // one extra to leave room for the adder carry
  assign exp_o      = (exp_a_less ? exp_b_i : exp_a_i) + 1'b1;

  // hidden bit only under a nonzero exponent, so zeros add as zero
  assign man_a_norm = {|exp_a_i, man_a_i};
  assign man_b_norm = {|exp_b_i, man_b_i};
  assign big_norm   = exp_a_less ? man_b_norm : man_a_norm;
  assign small_norm = exp_a_less ? man_a_norm : man_b_norm;

  assign small_pad = {small_norm, {(fpu_pkg::grs_width-1){1'b0}}};
  // ones where bits fall off the bottom
  assign lost_mask = ~({pad_width_lp{1'b1}} << exp_diff);
  assign sticky    = |(small_pad & lost_mask);

  assign big_man_o   = {big_norm, {fpu_pkg::grs_width{1'b0}}};
  assign small_man_o = {small_pad >> exp_diff, sticky};

  assign mag_a_less = a_i[exp_width_p+man_width_p-1:0] < b_i[exp_width_p+man_width_p-1:0];
  assign sign_o     = mag_a_less ? (sign_b_i ^ sub_i) : sign_a_i;
  assign do_sub_o   = sub_i ^ sign_a_i ^ sign_b_i;

  // a far operand leaves only its sticky bit behind
  always_comb begin
    if (exp_diff > (man_width_p + fpu_pkg::grs_width)) begin
      assert (small_man_o == {{pad_width_lp{1'b0}}, |small_norm})
        else $error("align: far operand not folded into sticky");
    end
  end

endmodule

// ==== fpu_classify.sv ====
`timescale 1ns/1ns
//////////////////////////////
// fp operand classifier
// splits one operand into fields and flags
// zero, nan, snan, infinity and denormal
//////////////////////////////
module fpu_classify #(
  parameter int exp_width_p = fpu_pkg::exp_width_default,
  parameter int man_width_p = fpu_pkg::man_width_default
) (
  input  logic [exp_width_p+man_width_p:0] a_i,
  output logic                             sign_o,
  output logic [exp_width_p-1:0]           exp_o,
  output logic [man_width_p-1:0]           man_o,
  output logic                             zero_o,
  output logic                             nan_o,
  output logic                             sig_nan_o,
  output logic                             infty_o,
  output logic                             denormal_o
);

  logic exp_ones;
  logic exp_zero;
  logic man_zero;

  assign sign_o = a_i[exp_width_p+man_width_p];
  assign exp_o  = a_i[man_width_p +: exp_width_p];
  assign man_o  = a_i[man_width_p-1:0];

  assign exp_ones = &exp_o;
  assign exp_zero = ~|exp_o;
  assign man_zero = ~|man_o;

  assign zero_o     = exp_zero & man_zero;
  assign nan_o      = exp_ones & ~man_zero;
  // quiet bit clear means signaling
  assign sig_nan_o  = nan_o & ~man_o[man_width_p-1];
  assign infty_o    = exp_ones & man_zero;
  assign denormal_o = exp_zero & ~man_zero;

endmodule

// ==== fpu_pkg.sv ====
//////////////////////////////
// fpu package
// default widths, guard bit count and the
// exception flag vector shared by the fp adder
//////////////////////////////
package fpu_pkg;

  // single precision unless the top level says otherwise
  localparam int exp_width_default = 8;
  localparam int man_width_default = 23;

  // guard, round and sticky appended below the fraction
  localparam int grs_width = 3;

  // exception flags carried with every result
  typedef logic [3:0] fpu_flags_t;

  // denormal input seen
  localparam int flag_unimpl_idx = 3;

  // signaling nan or inf - inf
  localparam int flag_invalid_idx = 2;

  // rounded exponent hit all ones
  localparam int flag_overflow_idx = 1;

  // result flushed to zero
  localparam int flag_underflow_idx = 0;

endpackage
